// ==== Bender.yml ====
package:
  name: dmem_subsystem

sources:
  - files:
      - rtl/dmem_pkg.sv
      - rtl/dmem_bus_adapter.sv
      - rtl/dmem_region_router.sv
      - rtl/dmem_region_ram.sv
      - rtl/dmem_access_counters.sv
      - rtl/dmem_subsystem_top.sv
  - target: simulation
    files:
      - bench/dmem_checker.sv
      - bench/dmem_assertions.sv
      - bench/dmem_tb.sv

// ==== bench/dmem_assertions.sv ====
// Bound checks on the core response pulses and the region RAM selects
`timescale 1ns/1ps

module dmem_assertions (
    input logic                clk_i,
    input logic                rst_n_i,
    input dmem_pkg::core_rsp_t core_rsp_i,
    input dmem_pkg::wb_req_t   bus_req_i,
    input dmem_pkg::wb_req_t   r0_req_i,
    input dmem_pkg::wb_req_t   r1_req_i
);

    import dmem_pkg::*;

    int fails;                  // Failed assertions so far

    // ack and err are exclusive
    rsp_exclusive: assert property (@(posedge clk_i) disable iff (rst_n_i)
        !(core_rsp_i.ack && core_rsp_i.err))
        else begin
            $error("core_rsp ack and err high together");
            fails++;
        end

    // Each response lasts a single cycle
    ack_one_cycle: assert property (@(posedge clk_i) disable iff (rst_n_i)
        core_rsp_i.ack |=> !core_rsp_i.ack)
        else begin
            $error("core_rsp ack held longer than one cycle");
            fails++;
        end

    err_one_cycle: assert property (@(posedge clk_i) disable iff (rst_n_i)
        core_rsp_i.err |=> !core_rsp_i.err)
        else begin
            $error("core_rsp err held longer than one cycle");
            fails++;
        end

    // Each RAM strobed only inside its own region, so never both at once
    r0_sel_in_region: assert property (@(posedge clk_i) disable iff (rst_n_i)
        r0_req_i.stb |-> (bus_req_i.adr >= REGION0_BASE &&
                          bus_req_i.adr <= REGION0_BASE + 4 * (REGION0_WORDS - 1)))
        else begin
            $error("region 0 RAM sees stb for an address outside region 0");
            fails++;
        end

    r1_sel_in_region: assert property (@(posedge clk_i) disable iff (rst_n_i)
        r1_req_i.stb |-> (bus_req_i.adr >= REGION1_BASE &&
                          bus_req_i.adr <= REGION1_BASE + 4 * (REGION1_WORDS - 1)))
        else begin
            $error("region 1 RAM sees stb for an address outside region 1");
            fails++;
        end

endmodule

bind dmem_subsystem_top dmem_assertions u_assertions (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .core_rsp_i (core_rsp_o),
    .bus_req_i  (bus_req),
    .r0_req_i   (r0_req),
    .r1_req_i   (r1_req)
);

// ==== bench/dmem_checker.sv ====
// Data memory checker
// Shadow model of both regions, response timing, tallies and counter comparison
`timescale 1ns/1ps

module dmem_checker (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  dmem_pkg::core_req_t core_req_i,
    input  dmem_pkg::core_rsp_t core_rsp_i,
    input  dmem_pkg::perf_cnt_t perf_i,
    output int                  errors_o        // Total mismatches so far
);

    import dmem_pkg::*;

    logic [31:0] shadow0 [REGION0_WORDS];       // Expected contents, region 0
    logic [31:0] shadow1 [REGION1_WORDS];
    bit   [3:0]  mask0 [REGION0_WORDS];         // Bytes ever written
    bit   [3:0]  mask1 [REGION1_WORDS];
    core_req_t   cur;                           // Request in flight
    bit          busy;
    int          age;                           // Edges since the sampling edge
    int          mismatches;
    int          tests;
    int          test_accs;
    int          test_errs;
    int          n_reads;
    int          n_writes;
    int          n_errs;
    logic [31:0] last_cycles;
    bit          have_cycles;

    assign errors_o = mismatches;

    // ==================================================
    // Reference model
    // ==================================================

    // Region of a byte address, -1 if unmapped; idx gets the word index
    function automatic int word_slot(input logic [31:0] addr, output int idx);
        longint a;
        a   = longint'(addr);
        idx = 0;
        if (a >= longint'(REGION0_BASE) && a < longint'(REGION0_BASE) + 4 * REGION0_WORDS) begin
            idx = int'((a - longint'(REGION0_BASE)) / 4);
            return 0;
        end
        if (a >= longint'(REGION1_BASE) && a < longint'(REGION1_BASE) + 4 * REGION1_WORDS) begin
            idx = int'((a - longint'(REGION1_BASE)) / 4);
            return 1;
        end
        return -1;
    endfunction

    // Expected err flag, read data and the bytes that hold known data
    function automatic void predict(input logic [31:0] addr, output logic exp_err,
                                    output logic [31:0] exp_data, output logic [3:0] valid);
        int idx;
        int region;
        region   = word_slot(addr, idx);
        exp_err  = (region < 0);
        exp_data = '0;
        valid    = '0;
        if (region == 0) begin
            exp_data = shadow0[idx];
            valid    = mask0[idx];
        end else if (region == 1) begin
            exp_data = shadow1[idx];
            valid    = mask1[idx];
        end
    endfunction

    task automatic update_shadow(input core_req_t r);
        int idx;
        int region;
        region = word_slot(r.addr, idx);
        for (int b = 0; b < BE_W; b++) begin
            if (r.be[b] && region == 0) begin
                shadow0[idx][8*b +: 8] = r.wdata[8*b +: 8];
                mask0[idx][b]          = 1'b1;
            end else if (r.be[b] && region == 1) begin
                shadow1[idx][8*b +: 8] = r.wdata[8*b +: 8];
                mask1[idx][b]          = 1'b1;
            end
        end
    endtask

    // ==================================================
    // Reporting
    // ==================================================

    task automatic value_error(input string sig, input logic [31:0] exp, input logic [31:0] got);
        $display("** Error at %0t ns: %s expected %h got %h", $time, sig, exp, got);
        mismatches++;
        test_errs++;
    endtask

    task automatic other_error(input string what);
        $display("** Error at %0t ns: %s", $time, what);
        mismatches++;
        test_errs++;
    endtask

    task automatic report_test(input string name);
        $display("Test %-10s %4d accesses, %0d mismatches", name, test_accs, test_errs);
        tests++;
        test_accs = 0;
        test_errs = 0;
    endtask

    task automatic summary();
        $display("Totals: %0d tests, %0d reads, %0d writes, %0d err responses, %0d mismatches",
                 tests, n_reads, n_writes, n_errs, mismatches);
    endtask

    // perf lags the last completion by a cycle, call after a short idle
    task automatic compare_counters();
        if (perf_i.reads !== 32'(n_reads)) value_error("perf.reads", n_reads, perf_i.reads);
        if (perf_i.writes !== 32'(n_writes)) value_error("perf.writes", n_writes, perf_i.writes);
        if (perf_i.errors !== 32'(n_errs)) value_error("perf.errors", n_errs, perf_i.errors);
        if (perf_i.cycles == 0) other_error("cycle counter still zero at the end of the run");
    endtask

    task automatic check_response();
        logic        exp_err;
        logic [31:0] exp_data;
        logic [3:0]  valid;
        logic [31:0] keep;
        predict(cur.addr, exp_err, exp_data, valid);
        test_accs++;
        if (core_rsp_i.err !== exp_err) value_error("core_rsp.err", exp_err, core_rsp_i.err);
        if (core_rsp_i.ack !== ~exp_err) value_error("core_rsp.ack", ~exp_err, core_rsp_i.ack);
        if (exp_err) begin
            n_errs++;                            // Memory must stay untouched
        end else if (cur.we) begin
            n_writes++;
            update_shadow(cur);
        end else begin
            n_reads++;
            keep = {{8{valid[3]}}, {8{valid[2]}}, {8{valid[1]}}, {8{valid[0]}}};
            if ((core_rsp_i.rdata & keep) !== (exp_data & keep)) begin
                value_error("core_rsp.rdata", exp_data & keep, core_rsp_i.rdata & keep);
            end
        end
    endtask

    // ==================================================
    // Port monitor, inputs settle at the falling edge
    // ==================================================

    always @(posedge clk_i) begin : watch
        logic pulse;
        pulse = core_rsp_i.ack | core_rsp_i.err;
        if (rst_n_i) begin
            busy        = 1'b0;
            have_cycles = 1'b0;
        end else begin
            if (!busy) begin
                if (pulse) other_error("response pulse with no request outstanding");
                if (core_req_i.req) begin
                    cur  = core_req_i;               // Fields held until the pulse
                    busy = 1'b1;
                    age  = 0;
                end
            end else begin
                age++;
                if (pulse && age != 3) begin
                    other_error($sformatf("response %0d cycles after the request, not 3", age));
                    busy = 1'b0;
                end else if (age == 3) begin
                    if (pulse) check_response();
                    else other_error("no response 3 cycles after the request");
                    busy = 1'b0;                     // req at this edge is ignored by the DUT
                end
            end
            if (have_cycles && perf_i.cycles <= last_cycles) begin
                value_error("perf.cycles", last_cycles + 32'd1, perf_i.cycles);
            end
            last_cycles = perf_i.cycles;
            have_cycles = 1'b1;
        end
    end

endmodule

// ==== bench/dmem_tb.sv ====
// Data memory subsystem testbench
// Directed and random accesses over both regions, verdict from the checker
`timescale 1ns/1ps

module dmem_tb;

    import dmem_pkg::*;

    localparam int RSP_TIMEOUT = 20;            // Cycles allowed per response
    localparam int N_RANDOM    = 300;

    logic        clk;
    logic        rst_n;
    core_req_t   core_req;
    core_rsp_t   core_rsp;
    perf_cnt_t   perf;
    int          check_errors;
    bit          timed_out;
    logic [31:0] lfsr_state;

    dmem_subsystem_top i_dut (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .core_req_i (core_req),
        .core_rsp_o (core_rsp),
        .perf_o     (perf)
    );

    dmem_checker u_checker (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .core_req_i (core_req),
        .core_rsp_i (core_rsp),
        .perf_i     (perf),
        .errors_o   (check_errors)
    );

    always #5 clk = ~clk;                       // 10 ns period

    // ==================================================
    // Random source, x^32 + x^22 + x^2 + x + 1
    // ==================================================

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Near either end of each region, or just outside
    function automatic logic [31:0] random_addr();
        logic [2:0]  kind;
        logic [31:0] word;
        kind = take_bits(3);
        word = take_bits(5);
        case (kind)
            3'd0, 3'd1: return REGION0_BASE + 4 * word;
            3'd2:       return REGION0_BASE + 4 * (REGION0_WORDS - 1 - word);
            3'd3, 3'd4: return REGION1_BASE + 4 * word;
            3'd5:       return REGION1_BASE + 4 * (REGION1_WORDS - 1 - word);
            3'd6:       return REGION0_BASE + 4 * (REGION0_WORDS + word);   // Past region 0
            default:    return REGION1_BASE - 4 * (word + 1);               // Below region 1
        endcase
    endfunction

    // ==================================================
    // Stimulus, entered and left at a falling edge
    // ==================================================

    task automatic access(input logic we, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] be);
        int waited;
        bit got;
        if (!timed_out) begin
            core_req.req   = 1'b1;
            core_req.we    = we;
            core_req.addr  = addr;
            core_req.wdata = wdata;
            core_req.be    = be;
            waited = 0;
            got    = 1'b0;
            while (!got && waited < RSP_TIMEOUT) begin
                @(negedge clk);
                waited++;
                got = core_rsp.ack | core_rsp.err;
            end
            core_req.req = 1'b0;                // Next access may raise it again now
            if (!got) begin
                $display("Timeout: no response for address %h after %0d cycles",
                         addr, RSP_TIMEOUT);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    initial begin
        logic [31:0] edge_addr [4];
        logic [31:0] outside [5];
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic        we;
        clk        = 1'b0;
        rst_n      = 1'b1;
        core_req   = '0;
        timed_out  = 1'b0;
        lfsr_state = 32'h7ee295dc;
        edge_addr  = '{REGION0_BASE, REGION0_BASE + 4 * (REGION0_WORDS - 1),
                       REGION1_BASE, REGION1_BASE + 4 * (REGION1_WORDS - 1)};
        outside    = '{REGION0_BASE + 4 * REGION0_WORDS, REGION1_BASE - 4,
                       REGION1_BASE + 4 * REGION1_WORDS, 32'hffff_fffc, 32'hc000_0000};
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b0;

        idle(6);                                // No stray pulse after reset
        u_checker.report_test("reset");

        // First and last word of each region, then a partial overwrite
        for (int i = 0; i < 4; i++) access(1'b1, edge_addr[i], 32'hc0de_0000 | i, 4'hf);
        access(1'b1, edge_addr[2], 32'h1122_3344, 4'b0101);
        for (int i = 0; i < 4; i++) access(1'b0, edge_addr[i], '0, 4'hf);
        u_checker.report_test("edges");

        for (int i = 0; i < 5; i++) begin
            access(1'b1, outside[i], 32'hdead_beef, 4'hf);
            access(1'b0, outside[i], '0, 4'hf);
        end
        for (int i = 0; i < 4; i++) access(1'b0, edge_addr[i], '0, 4'hf);
        u_checker.report_test("unmapped");

        for (int i = 0; i < N_RANDOM; i++) begin
            addr  = random_addr();
            we    = take_bits(1);
            wdata = take_bits(32);
            be    = take_bits(4);
            access(we, addr, wdata, be);
            if (take_bits(3) == 0) idle(1 + int'(take_bits(2)));
        end
        u_checker.report_test("random");

        idle(3);                                // Let the counters catch up
        u_checker.compare_counters();
        u_checker.report_test("counters");
        u_checker.summary();

        if (timed_out || check_errors != 0 || i_dut.u_assertions.fails != 0) begin
            $display("Regression failed");
        end else begin
            $display("Regression passed");
        end
        $finish;
    end

endmodule

// ==== rtl/dmem_access_counters.sv ====
// Data access performance counters
// Cycles, reads, writes and error responses, all free running
`timescale 1ns/1ps

module dmem_access_counters (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                done_i,     // One pulse per finished access
    input  logic                done_we_i,
    input  logic                done_err_i,
    output dmem_pkg::perf_cnt_t perf_o
);

    import dmem_pkg::*;

    perf_cnt_t perf_q;

    // ==================================================
    // Counter update
    // ==================================================

    always_ff @(posedge clk_i) begin
        if (rst_n_i) begin
            perf_q <= '0;
        end else begin
            perf_q.cycles <= perf_q.cycles + 32'd1;       // Every cycle out of reset

            // Exactly one bucket per completion, err first
            if (done_i) begin
                if (done_err_i) begin
                    perf_q.errors <= perf_q.errors + 32'd1;
                end else if (done_we_i) begin
                    perf_q.writes <= perf_q.writes + 32'd1;
                end else begin
                    perf_q.reads  <= perf_q.reads + 32'd1;
                end
            end
        end
    end

    assign perf_o = perf_q;     // Lags the completion pulse by one cycle

endmodule

// ==== rtl/dmem_bus_adapter.sv ====
// Core data port to internal bus adapter
// Turns a held core request into one bus cycle and a one-cycle response
`timescale 1ns/1ps

module dmem_bus_adapter (
    input  logic                clk_i,
    input  logic                rst_n_i,      // Synchronous, active high
    input  dmem_pkg::core_req_t core_req_i,
    output dmem_pkg::core_rsp_t core_rsp_o,
    output dmem_pkg::wb_req_t   bus_req_o,
    input  dmem_pkg::wb_rsp_t   bus_rsp_i,
    output logic                done_o,       // Completion pulse for the counters
    output logic                done_we_o,
    output logic                done_err_o
);

    import dmem_pkg::*;

    adapter_state_e state_q;

    // Request payload, captured in ST_IDLE
    logic              we_q;
    logic [DATA_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [BE_W-1:0]   be_q;

    // Bus response, captured at the end of ST_BUS
    logic              ack_q;
    logic              err_q;
    logic [DATA_W-1:0] rdata_q;

    logic bus_done;
    assign bus_done = bus_rsp_i.ack | bus_rsp_i.err;   // Slave ends the cycle

    // ==================================================
    // FSM and response flags
    // ==================================================

    always_ff @(posedge clk_i) begin
        if (rst_n_i) begin
            state_q <= ST_IDLE;
            ack_q   <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (core_req_i.req) state_q <= ST_BUS;  // Open bus next cycle
                end
                ST_BUS: begin
                    if (bus_done) begin
                        ack_q   <= bus_rsp_i.ack & ~bus_rsp_i.err;  // err wins
                        err_q   <= bus_rsp_i.err;
                        state_q <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    // req still high here from the core, not sampled
                    state_q <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && core_req_i.req) begin
            we_q    <= core_req_i.we;
            addr_q  <= core_req_i.addr;
            wdata_q <= core_req_i.wdata;
            be_q    <= core_req_i.be;
        end
        if (state_q == ST_BUS && bus_done) begin
            rdata_q <= bus_rsp_i.dat;             // Zero on router err
        end
    end

    // ==================================================
    // Outputs
    // ==================================================

    always_comb begin
        bus_req_o.cyc = (state_q == ST_BUS);      // Held until slave answers
        bus_req_o.stb = (state_q == ST_BUS);
        bus_req_o.we  = we_q;
        bus_req_o.adr = addr_q;
        bus_req_o.dat = wdata_q;
        bus_req_o.sel = be_q;
    end

    // Response visible only for the single ST_RESP cycle
    always_comb begin
        core_rsp_o.ack   = (state_q == ST_RESP) & ack_q;
        core_rsp_o.err   = (state_q == ST_RESP) & err_q;
        core_rsp_o.rdata = rdata_q;
    end

    assign done_o     = (state_q == ST_RESP);
    assign done_we_o  = we_q;
    assign done_err_o = err_q;

endmodule

// ==== rtl/dmem_pkg.sv ====
// Data memory subsystem shared types
// Bus structs, FSM and region enums, region map and counter block

package dmem_pkg;

    // ==================================================
    // Widths
    // ==================================================

    localparam int DATA_W = 32;                 // Data and address width
    localparam int BE_W   = DATA_W / 8;         // One enable per byte lane

    // ==================================================
    // Region map
    // ==================================================

    // Region 0 at the bottom of the address space
    localparam logic [DATA_W-1:0] REGION0_BASE  = 32'h0000_0000;
    localparam int                REGION0_WORDS = 1024;     // 4 KB

    // Region 1 sits just below the 2 GB line
    localparam logic [DATA_W-1:0] REGION1_BASE  = 32'h7FFE_FFF0;
    localparam int                REGION1_WORDS = 4096;     // 16 KB

    // ==================================================
    // Core side handshake
    // ==================================================

    typedef struct packed {
        logic              req;                 // Level, held until ack or err
        logic              we;                  // 1 = write
        logic [DATA_W-1:0] addr;                // Byte address
        logic [DATA_W-1:0] wdata;
        logic [BE_W-1:0]   be;                  // Byte enables
    } core_req_t;

    typedef struct packed {
        logic              ack;                 // One cycle pulse
        logic              err;                 // One cycle pulse, never with ack
        logic [DATA_W-1:0] rdata;               // Valid with read ack
    } core_rsp_t;

    // ==================================================
    // Internal Wishbone style bus
    // ==================================================

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [DATA_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        logic [BE_W-1:0]   sel;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic              err;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

    // Access statistics, all wrap at 32 bits
    typedef struct packed {
        logic [31:0] cycles;
        logic [31:0] reads;
        logic [31:0] writes;
        logic [31:0] errors;
    } perf_cnt_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,                         // Waiting for core req
        ST_BUS  = 2'd1,                         // Bus cycle open
        ST_RESP = 2'd2                          // Response pulse to core
    } adapter_state_e;

    typedef enum logic [1:0] {
        REG_0    = 2'd0,
        REG_1    = 2'd1,
        REG_NONE = 2'd2                         // Unmapped, answered with err
    } region_e;

endpackage

// ==== rtl/dmem_region_ram.sv ====
// Single-port data RAM for one region
// Word array with byte enables, registered read data and ack
`timescale 1ns/1ps

module dmem_region_ram #(
    parameter int DEPTH_WORDS = dmem_pkg::REGION0_WORDS
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  dmem_pkg::wb_req_t bus_req_i,
    output dmem_pkg::wb_rsp_t bus_rsp_o
);

    import dmem_pkg::*;

    localparam int AW = $clog2(DEPTH_WORDS);  // Word index bits

    logic [DATA_W-1:0] mem [DEPTH_WORDS];
    logic [DATA_W-1:0] rdata_q;
    logic              ack_q;
    logic              access;
    logic [AW-1:0]     idx;

    // One access per bus cycle, ack_q blocks the repeat while stb is still up
    assign access = bus_req_i.cyc & bus_req_i.stb & ~ack_q;
    assign idx    = bus_req_i.adr[AW-1:0];      // Router already stripped base

    // ==================================================
    // Array
    // ==================================================

    always_ff @(posedge clk_i) begin
        if (access) begin
            if (bus_req_i.we) begin
                for (int b = 0; b < BE_W; b++) begin
                    if (bus_req_i.sel[b]) mem[idx][8*b +: 8] <= bus_req_i.dat[8*b +: 8];
                end
            end
            rdata_q <= mem[idx];                // Old data, only meaningful on reads
        end
    end

    // Ack one cycle after stb
    always_ff @(posedge clk_i) begin
        if (rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_comb begin
        bus_rsp_o.ack = ack_q;
        bus_rsp_o.err = 1'b0;                   // Range checked upstream
        bus_rsp_o.dat = rdata_q;
    end

endmodule

// ==== rtl/dmem_region_router.sv ====
// Data memory region router
// Decodes the bus address to region 0, region 1 or an error reply
`timescale 1ns/1ps

module dmem_region_router (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  dmem_pkg::wb_req_t bus_req_i,
    output dmem_pkg::wb_rsp_t bus_rsp_o,
    output dmem_pkg::wb_req_t r0_req_o,
    input  dmem_pkg::wb_rsp_t r0_rsp_i,
    output dmem_pkg::wb_req_t r1_req_o,
    input  dmem_pkg::wb_rsp_t r1_rsp_i
);

    import dmem_pkg::*;

    logic [DATA_W-1:0] off0;              // Byte offset into region 0
    logic [DATA_W-1:0] off1;              // Byte offset into region 1
    region_e           region;
    logic              none_err_q;        // Err reply for unmapped accesses

    // ==================================================
    // Address decode
    // ==================================================

    // One unsigned compare per region, addresses below base wrap to huge offsets
    always_comb begin
        off0 = bus_req_i.adr - REGION0_BASE;
        off1 = bus_req_i.adr - REGION1_BASE;
        if (off0 < DATA_W'(REGION0_WORDS * 4)) begin
            region = REG_0;
        end else if (off1 < DATA_W'(REGION1_WORDS * 4)) begin
            region = REG_1;
        end else begin
            region = REG_NONE;
        end
    end

    // ==================================================
    // Request fanout
    // ==================================================

    always_comb begin
        r0_req_o     = bus_req_i;
        r0_req_o.adr = {2'b00, off0[DATA_W-1:2]};            // Word offset
        r0_req_o.cyc = bus_req_i.cyc & (region == REG_0);
        r0_req_o.stb = bus_req_i.stb & (region == REG_0);    // Only selected RAM sees stb

        r1_req_o     = bus_req_i;
        r1_req_o.adr = {2'b00, off1[DATA_W-1:2]};
        r1_req_o.cyc = bus_req_i.cyc & (region == REG_1);
        r1_req_o.stb = bus_req_i.stb & (region == REG_1);
    end

    // Unmapped access, err one cycle after stb, pulse even if stb stays up
    always_ff @(posedge clk_i) begin
        if (rst_n_i) begin
            none_err_q <= 1'b0;
        end else begin
            none_err_q <= bus_req_i.cyc & bus_req_i.stb &
                          (region == REG_NONE) & ~none_err_q;
        end
    end

    // ==================================================
    // Response mux
    // ==================================================

    always_comb begin
        case (region)
            REG_0: bus_rsp_o = r0_rsp_i;
            REG_1: bus_rsp_o = r1_rsp_i;
            default: begin
                bus_rsp_o.ack = 1'b0;             // Never ack an unmapped address
                bus_rsp_o.err = none_err_q;
                bus_rsp_o.dat = '0;
            end
        endcase
    end

endmodule

// ==== rtl/dmem_subsystem_top.sv ====
// Data memory subsystem top level
// Adapter, region router, two region RAMs and access counters
`timescale 1ns/1ps

module dmem_subsystem_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  dmem_pkg::core_req_t core_req_i,
    output dmem_pkg::core_rsp_t core_rsp_o,
    output dmem_pkg::perf_cnt_t perf_o
);

    import dmem_pkg::*;

    wb_req_t bus_req;           // Adapter to router
    wb_rsp_t bus_rsp;
    wb_req_t r0_req;            // Router to region 0 RAM
    wb_rsp_t r0_rsp;
    wb_req_t r1_req;            // Router to region 1 RAM
    wb_rsp_t r1_rsp;

    logic done;
    logic done_we;
    logic done_err;

    // ==================================================
    // Core side
    // ==================================================

    dmem_bus_adapter u_adapter (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .core_req_i (core_req_i),
        .core_rsp_o (core_rsp_o),
        .bus_req_o  (bus_req),
        .bus_rsp_i  (bus_rsp),
        .done_o     (done),
        .done_we_o  (done_we),
        .done_err_o (done_err)
    );

    dmem_region_router u_router (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .bus_req_i (bus_req),
        .bus_rsp_o (bus_rsp),
        .r0_req_o  (r0_req),
        .r0_rsp_i  (r0_rsp),
        .r1_req_o  (r1_req),
        .r1_rsp_i  (r1_rsp)
    );

    // ==================================================
    // Region memories and statistics
    // ==================================================

    dmem_region_ram #(.DEPTH_WORDS(REGION0_WORDS)) u_ram0 (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .bus_req_i (r0_req),
        .bus_rsp_o (r0_rsp)
    );

    dmem_region_ram #(.DEPTH_WORDS(REGION1_WORDS)) u_ram1 (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .bus_req_i (r1_req),
        .bus_rsp_o (r1_rsp)
    );

    dmem_access_counters u_counters (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .done_i     (done),
        .done_we_i  (done_we),
        .done_err_i (done_err),
        .perf_o     (perf_o)
    );

endmodule

// ==== sim.f ====
rtl/dmem_pkg.sv
rtl/dmem_bus_adapter.sv
rtl/dmem_region_router.sv
rtl/dmem_region_ram.sv
rtl/dmem_access_counters.sv
rtl/dmem_subsystem_top.sv
bench/dmem_checker.sv
bench/dmem_assertions.sv
bench/dmem_tb.sv
